/* source/hyp_pkg.sv */
`default_nettype none

package hyp_pkg;

    // Operand and result widths
    localparam int unsigned op_w   = 8;
    localparam int unsigned sq_w   = 2 * op_w;
    localparam int unsigned sum_w  = sq_w + 1;         // Carry bit keeps large sums exact
    localparam int unsigned root_w = 8;                // Also the number of root trials

    // Width of the root bit-position counter
    localparam int unsigned idx_w = $clog2(root_w);

    // SAMPLE + SUM + START + 8 root cycles + PUBLISH
    localparam int unsigned loop_cycles = 12;

    // Loop states of the sequencer
    typedef enum logic [2:0] {
        SAMPLE  = 3'd0,
        SUM     = 3'd1,
        START   = 3'd2,
        ROOT    = 3'd3,
        PUBLISH = 3'd4
    } hyp_state_e;

    // One sampled operand pair
    typedef struct packed {
        logic [op_w-1:0] x;
        logic [op_w-1:0] y;
    } operands_t;

endpackage

`default_nettype wire

/* source/square_sum.sv */
`timescale 1ns/10ps
`default_nettype none

module square_sum (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      sample,
    input  logic                      add,
    input  hyp_pkg::operands_t        operands,
    output logic [hyp_pkg::sum_w-1:0] sum
);

    import hyp_pkg::*;

    logic [sq_w-1:0]  sq_x_d;
    logic [sq_w-1:0]  sq_y_d;
    logic [sq_w-1:0]  sq_x_q;
    logic [sq_w-1:0]  sq_y_q;
    logic [sum_w-1:0] sum_d;

    // Products are formed at full square width
    always_comb begin
        sq_x_d = sq_w'(operands.x) * sq_w'(operands.x);
        sq_y_d = sq_w'(operands.y) * sq_w'(operands.y);
    end

    assign sum_d = sum_w'(sq_x_q) + sum_w'(sq_y_q);

    // Squares captured on the sample strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sq_x_q <= '0;
            sq_y_q <= '0;
        end else if (sample) begin
            sq_x_q <= sq_x_d;
            sq_y_q <= sq_y_d;
        end
    end

    // Radicand stays put for the whole root search
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (add) begin
            sum <= sum_d;
        end
    end

endmodule

`default_nettype wire

/* source/isqrt_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module isqrt_seq (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [hyp_pkg::sum_w-1:0]  sum,
    output logic [hyp_pkg::root_w-1:0] root,
    output logic                       done
);

    import hyp_pkg::*;

    logic [sum_w-1:0]    rad_q;
    logic [root_w-1:0]   root_q;
    logic [idx_w-1:0]    bit_q;
    logic                busy_q;
    logic                done_q;

    logic [sum_w-1:0]    src_rad;
    logic [root_w-1:0]   src_root;
    logic [idx_w-1:0]    src_bit;
    logic [root_w-1:0]   cand;
    logic [2*root_w-1:0] cand_sq;
    logic                keep;
    logic                step;

    assign step = start | busy_q;

    // On start the first trial runs against the fresh radicand with a cleared root
    always_comb begin
        if (start) begin
            src_rad  = sum;
            src_root = '0;
            src_bit  = idx_w'(root_w - 1);
        end else begin
            src_rad  = rad_q;
            src_root = root_q;
            src_bit  = bit_q;
        end
    end

    // Trial root with the next lower bit set
    assign cand    = src_root | (root_w'(1) << src_bit);
    assign cand_sq = (2*root_w)'(cand) * (2*root_w)'(cand);
    assign keep    = sum_w'(cand_sq) <= src_rad;

    always_ff @(posedge clk) begin
        if (start) begin
            rad_q <= sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            root_q <= '0;
            bit_q  <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (step) begin
                root_q <= keep ? cand : src_root;  // Restore when the square overshoots
                if (src_bit == '0) begin
                    // Bit 0 decided, root is final
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    busy_q <= 1'b1;
                    bit_q  <= src_bit - 1'b1;
                end
            end
        end
    end

    assign root = root_q;   // Holds until the next start
    assign done = done_q;

endmodule

`default_nettype wire

/* source/hyp_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module hyp_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ena,
    input  logic                       done,
    input  logic [hyp_pkg::root_w-1:0] root,
    output logic                       sample,
    output logic                       add,
    output logic                       start,
    output logic [hyp_pkg::root_w-1:0] result
);

    import hyp_pkg::*;

    hyp_state_e state_q;
    hyp_state_e state_d;
    logic       publish;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SAMPLE: begin
                if (ena) begin
                    state_d = SUM;
                end
            end
            SUM: begin
                if (ena) begin
                    state_d = START;
                end
            end
            START: begin
                if (ena) begin
                    state_d = ROOT;
                end
            end
            ROOT: begin
                // A running root always completes, ena or not
                if (done) begin
                    state_d = PUBLISH;
                end
            end
            PUBLISH: begin
                if (ena) begin
                    state_d = SAMPLE;
                end
            end
            default: state_d = SAMPLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= SAMPLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Strobes fire only in the cycle the state moves on
    assign sample  = ena && (state_q == SAMPLE);
    assign add     = ena && (state_q == SUM);
    assign start   = ena && (state_q == START);
    assign publish = ena && (state_q == PUBLISH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (publish) begin
            result <= root;
        end
    end

endmodule

`default_nettype wire

/* source/tt_um_addon.sv */
`timescale 1ns/10ps
`default_nettype none

module tt_um_addon (
    input  logic [7:0] ui_in,    // Operand x
    input  logic [7:0] uio_in,   // Operand y
    output logic [7:0] uo_out,   // Saturated hypotenuse
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n
);

    import hyp_pkg::*;

    operands_t         operands;
    logic              sample;
    logic              add;
    logic              start;
    logic              done;
    logic [sum_w-1:0]  sum;
    logic [root_w-1:0] root;
    logic [root_w-1:0] result;

    assign operands.x = ui_in;
    assign operands.y = uio_in;

    square_sum u_square_sum (
        .clk      (clk),
        .rst_n    (rst_n),
        .sample   (sample),
        .add      (add),
        .operands (operands),
        .sum      (sum)
    );

    isqrt_seq u_isqrt (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .sum   (sum),
        .root  (root),
        .done  (done)
    );

    hyp_sequencer u_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .ena    (ena),
        .done   (done),
        .root   (root),
        .sample (sample),
        .add    (add),
        .start  (start),
        .result (result)
    );

    assign uo_out = result;

    // Bidirectional pins stay inputs
    assign uio_out = 8'h00;
    assign uio_oe  = 8'h00;

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic por_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;    // 4 ns period
        end
    end

    // Power-on reset over the first 3 rising edges
    initial begin
        por_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        por_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/hyp_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module hyp_sva (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       ena,
    input logic                       sample,
    input logic                       start,
    input logic                       done,
    input logic [hyp_pkg::root_w-1:0] root,
    input logic [7:0]                 uo_out
);

    import hyp_pkg::*;

    int unsigned fail_count = 0;
    logic [7:0]  since_sample;    // Cycles since the last sample strobe
    logic        gap_seen;        // ena went low since that strobe

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_sample <= 8'(loop_cycles);
            gap_seen     <= 1'b1;
        end else if (sample) begin
            since_sample <= 8'd1;
            gap_seen     <= 1'b0;
        end else begin
            if (since_sample != 8'hff) begin
                since_sample <= since_sample + 8'd1;
            end
            if (!ena) begin
                gap_seen <= 1'b1;
            end
        end
    end

    // Uninterrupted loop restarts exactly one loop length later
    a_loop_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        (ena && !gap_seen && (since_sample == 8'(loop_cycles))) |-> sample)
        else begin
            $error("Loop did not restart after the expected number of cycles");
            fail_count++;
        end

    a_no_early_sample: assert property (@(posedge clk) disable iff (!rst_n)
        sample |-> (since_sample >= 8'(loop_cycles)))
        else begin
            $error("Operands sampled again before a full loop");
            fail_count++;
        end

    a_root_latency: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start, root_w))
        else begin
            $error("Root done pulse not eight cycles after start");
            fail_count++;
        end

    a_publish_value: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(uo_out) |-> (uo_out == root))
        else begin
            $error("Output changed to a value other than the finished root");
            fail_count++;
        end

endmodule

bind tt_um_addon hyp_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .ena     (ena),
    .sample  (sample),
    .start   (start),
    .done    (done),
    .root    (root),
    .uo_out  (uo_out)
);

`default_nettype wire

/* verification/tb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_top;

    import hyp_pkg::*;

    typedef enum logic [2:0] {
        DIRECTED,
        RANDOM,
        ENA_GAP,
        ENA_ROOT,
        RESET_MID
    } test_e;

    typedef struct packed {
        test_e           test;
        logic [op_w-1:0] x;
        logic [op_w-1:0] y;
        logic [7:0]      extra;    // ena-low cycles added to the loop
        logic [31:0]     at;       // Cycle of the sample strobe
    } sampled_t;

    localparam int unsigned n_random    = 40;
    localparam int unsigned n_tests     = 4 + n_random + 2 + 2 + 1;
    localparam int unsigned cycle_limit = (n_tests + 4) * loop_cycles * 2;

    logic        clk;
    logic        por_n;
    logic        force_rst;
    logic        rst_n;
    logic        ena;
    logic [7:0]  ui_in;
    logic [7:0]  uio_in;
    logic [7:0]  uo_out;
    logic [7:0]  uio_out;
    logic [7:0]  uio_oe;

    integer      seed;
    int unsigned cycle     = 0;
    int unsigned checks    = 0;
    int unsigned errors    = 0;
    int unsigned published = 0;
    test_e       cur_test;
    test_e       head_test;
    logic [7:0]  cur_extra;
    logic        watch_zero;
    logic        check_next = 1'b0;
    sampled_t    entry;
    sampled_t    head;
    sampled_t    pending_q[$];

    assign rst_n = por_n & ~force_rst;

    tb_clock u_clock (
        .clk   (clk),
        .por_n (por_n)
    );

    tt_um_addon u_dut (
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    // Saturated floor root by counting up
    function automatic int unsigned hyp_expected(input logic [7:0] x, input logic [7:0] y);
        int unsigned s;
        int unsigned r;
        s = 32'(x) * 32'(x) + 32'(y) * 32'(y);
        r = 0;
        while ((r < 255) && ((r + 1) * (r + 1) <= s)) begin
            r++;
        end
        return r;
    endfunction

    task automatic check_eq(input string name, input int unsigned exp, input int unsigned act);
        checks++;
        assert (act == exp) else begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic next_edge;
        @(posedge clk);
        #1;
    endtask

    // Hold a pair on the pins until the DUT samples it
    task automatic present(input logic [7:0] x, input logic [7:0] y, input logic [7:0] extra);
        ui_in     = x;
        uio_in    = y;
        cur_extra = extra;
        @(negedge clk);
        while (!u_dut.sample) begin
            @(negedge clk);
        end
        next_edge();
    endtask

    always @(negedge clk) begin
        if (watch_zero) begin
            check_eq("zero uo_out", 0, 32'(uo_out));
            check_eq("zero uio_out", 0, 32'(uio_out));
            check_eq("zero uio_oe", 0, 32'(uio_oe));
        end
        if (!rst_n) begin
            pending_q.delete();
            check_next = 1'b0;
        end else begin
            if (check_next) begin
                check_next = 1'b0;
                if (pending_q.size() == 0) begin
                    $display("Output was published with no sampled operands pending");
                    errors++;
                end else begin
                    head      = pending_q.pop_front();
                    head_test = head.test;
                    check_eq({head_test.name(), " value"}, hyp_expected(head.x, head.y),
                             32'(uo_out));
                    check_eq({head_test.name(), " latency"}, loop_cycles + 32'(head.extra),
                             cycle - head.at);
                    published++;
                end
            end
            if (u_dut.u_seq.publish) begin
                check_next = 1'b1;     // New value visible next cycle
            end
            if (u_dut.sample) begin
                entry.test  = cur_test;
                entry.x     = ui_in;
                entry.y     = uio_in;
                entry.extra = cur_extra;
                entry.at    = cycle;
                pending_q.push_back(entry);
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        seed       = 32'h30ee_5fb4;
        ena        = 1'b0;
        ui_in      = 8'd200;    // Nonzero pair that must not be published
        uio_in     = 8'd100;
        force_rst  = 1'b0;
        cur_test   = DIRECTED;
        cur_extra  = 8'd0;
        watch_zero = 1'b1;
        @(posedge por_n);
        repeat (2 * loop_cycles) next_edge();    // Idle with ena low
        watch_zero = 1'b0;
        ena        = 1'b1;

        present(8'd0, 8'd0, 8'd0);
        present(8'd3, 8'd4, 8'd0);
        present(8'd255, 8'd0, 8'd0);
        present(8'd255, 8'd255, 8'd0);

        cur_test = RANDOM;
        repeat (n_random) begin
            rnd = $random(seed);
            present(rnd[7:0], rnd[15:8], 8'd0);
        end

        // ena low while the sum waits
        cur_test = ENA_GAP;
        present(8'd200, 8'd150, 8'd5);
        ena = 1'b0;
        repeat (5) next_edge();
        ena = 1'b1;
        present(8'd17, 8'd250, 8'd3);
        ena = 1'b0;
        repeat (3) next_edge();
        ena = 1'b1;

        // ena low during the root search
        cur_test = ENA_ROOT;
        present(8'd120, 8'd209, 8'd0);
        repeat (2) next_edge();
        ena = 1'b0;
        repeat (4) next_edge();
        ena = 1'b1;
        present(8'd250, 8'd251, 8'd0);
        repeat (2) next_edge();
        ena = 1'b0;
        repeat (8) next_edge();    // Low through the done pulse
        ena = 1'b1;

        cur_test = RESET_MID;
        present(8'd90, 8'd60, 8'd0);    // Lost to the reset
        repeat (4) next_edge();
        force_rst  = 1'b1;
        watch_zero = 1'b1;
        repeat (3) next_edge();
        force_rst  = 1'b0;
        watch_zero = 1'b0;
        present(8'd77, 8'd201, 8'd0);

        while (published < n_tests) begin
            next_edge();
        end
        ena = 1'b0;
        repeat (2) next_edge();

        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 checks, errors, u_dut.u_sva.fail_count);
        if ((errors == 0) && (u_dut.u_sva.fail_count == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/hyp_pkg.sv
source/square_sum.sv
source/isqrt_seq.sv
source/hyp_sequencer.sv
source/tt_um_addon.sv
verification/tb_clock.sv
verification/hyp_sva.sv
verification/tb_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the hypotenuse testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f build.f \
    && ./obj_dir/Vtb_top +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "Simulation did not build or run" >> sim.log

cat sim.log
grep -q "Result: PASSED" sim.log && exit 0 || exit 1
